// ==== logic/mrr_loopback_pkg.sv ====
package mrr_loopback_pkg;

    localparam int ESAMP_WIDTH      = 16;
    localparam int OVERSAMPLE_LOG2  = 2;
    localparam int CYCLE_IDX_WIDTH  = 16;
    localparam int TX_BITS          = 32;
    localparam int TX_BIT_IDX_WIDTH = $clog2(TX_BITS);
    localparam int TX_SYMBOL_CYCLES = 5;
    localparam int TX_ONE_SLOT      = 0;
    localparam int TX_ZERO_SLOT     = 2;
    localparam int NUM_METADATA     = 7;
    localparam int META_IDX_WIDTH   = $clog2(NUM_METADATA);

    // A full cycle of four samples needs two extra sum bits and a count up to 4
    localparam int ESUM_WIDTH   = ESAMP_WIDTH + OVERSAMPLE_LOG2;
    localparam int ECOUNT_WIDTH = OVERSAMPLE_LOG2 + 1;

    typedef enum logic [2:0] {
        READY,
        RX_PAYLOAD,
        TURNAROUND,
        TX,
        GUARD,
        SEND_METADATA
    } loop_state_t;

    typedef struct packed {
        logic [15:0] wait_step;
        logic [31:0] tx_word;
        logic [7:0]  num_payload_bits;
        logic [7:0]  recharge_len;
        logic [15:0] guard_len;
        logic        tx_disable;
    } loopback_cfg_t;

    typedef struct packed {
        logic [31:0] cfo;
        logic [31:0] sfo;
        logic [63:0] timestamp;
        logic [31:0] corr;
        logic [63:0] extra;
    } rx_metadata_t;

    typedef struct packed {
        logic [ECOUNT_WIDTH-1:0] count;
        logic [ESUM_WIDTH-1:0]   sum;
    } energy_word_t;

    typedef struct packed {
        logic [31:0] data;
        logic        valid;
        logic        last;
    } decoded_beat_t;

endpackage

// ==== logic/mrr_cycle_timer.sv ====
`timescale 1ns/1ps

module mrr_cycle_timer
    import mrr_loopback_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_tvalid,
    input  logic                       i_tkeep,
    input  logic                       i_replay_flag,
    input  logic                       i_tready,
    input  logic                       i_timer_clear,
    input  logic                       i_cycle_clear,
    output logic                       o_accept,
    output logic                       o_cycle_end,
    output logic [CYCLE_IDX_WIDTH-1:0] o_cycle_idx
);

    localparam int COUNT_WIDTH = CYCLE_IDX_WIDTH + OVERSAMPLE_LOG2;

    // Low bits hold the sample phase inside a cycle, upper bits the MRR cycle
    logic [COUNT_WIDTH-1:0] count;
    logic [COUNT_WIDTH-1:0] count_next;

    // Replayed samples ignore the handshake and only look at keep
    assign o_accept    = i_replay_flag ? i_tkeep : (i_tready & i_tvalid & i_tkeep);
    assign o_cycle_end = o_accept && (count[OVERSAMPLE_LOG2-1:0] == '1);
    assign o_cycle_idx = count[COUNT_WIDTH-1:OVERSAMPLE_LOG2];

    always_comb begin
        count_next = count + COUNT_WIDTH'(o_accept);
        // The phase keeps running so a clear on a cycle end lands on sample 0
        if (i_cycle_clear) begin
            count_next[COUNT_WIDTH-1:OVERSAMPLE_LOG2] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || i_timer_clear) begin
            count <= '0;
        end else begin
            count <= count_next;
        end
    end

endmodule

// ==== logic/energy_integrator.sv ====
`timescale 1ns/1ps

module energy_integrator
    import mrr_loopback_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [ESAMP_WIDTH-1:0] i_sample,
    input  logic                   i_accept,
    input  logic                   i_cycle_end,
    input  logic                   i_integrate,
    output energy_word_t           o_word,
    output logic                   o_word_valid
);

    logic [ESUM_WIDTH-1:0]   sum;
    logic [ECOUNT_WIDTH-1:0] count;

    always_ff @(posedge clk) begin
        if (!i_integrate) begin
            sum   <= '0;
            count <= '0;
        end else if (i_accept && i_cycle_end) begin
            // Hand the finished cycle over and restart from zero
            o_word.sum   <= sum + ESUM_WIDTH'(i_sample);
            o_word.count <= count + 1'b1;
            sum          <= '0;
            count        <= '0;
        end else if (i_accept) begin
            sum   <= sum + ESUM_WIDTH'(i_sample);
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_word_valid <= 1'b0;
        end else begin
            o_word_valid <= i_integrate && i_accept && i_cycle_end;
        end
    end

endmodule

// ==== logic/loopback_sequencer.sv ====
`timescale 1ns/1ps

module loopback_sequencer
    import mrr_loopback_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_fm_flag,
    input  loopback_cfg_t              i_cfg,
    input  logic                       i_accept,
    input  logic                       i_cycle_end,
    input  logic [CYCLE_IDX_WIDTH-1:0] i_cycle_idx,
    input  logic                       i_cycle_wrap,
    input  logic                       i_tx_done,
    input  logic                       i_meta_done,
    output loop_state_t                o_state,
    output logic                       o_timer_clear,
    output logic                       o_cycle_clear,
    output logic                       o_integrate,
    output logic                       o_bit_last,
    output logic                       o_currently_decoding,
    output logic                       o_detector_reset,
    output logic                       o_tx_en
);

    loop_state_t state;
    loop_state_t next_state;

    logic [7:0]                 payload_bit_ctr;
    logic [15:0]                guard_ctr;
    logic [CYCLE_IDX_WIDTH-1:0] bit_last_idx;
    logic                       bit_end;
    logic                       last_bit;
    logic                       turn_end;
    logic                       guard_end;
    logic                       seq_clear;

    // A payload bit spans recharge_len + 3 cycles, so its last index is recharge_len + 2
    assign bit_last_idx = CYCLE_IDX_WIDTH'(i_cfg.recharge_len) + CYCLE_IDX_WIDTH'(2);
    assign bit_end      = (state == RX_PAYLOAD) && i_cycle_end && (i_cycle_idx == bit_last_idx);
    assign last_bit     = (payload_bit_ctr == i_cfg.num_payload_bits - 8'd1);

    assign turn_end = (i_cfg.wait_step == 16'd0) ||
                      (i_cycle_end && (i_cycle_idx == i_cfg.wait_step - 16'd1));

    // The guard is measured in accepted samples, not in MRR cycles
    assign guard_end = (i_cfg.guard_len == 16'd0) ||
                       (i_accept && (guard_ctr == i_cfg.guard_len - 16'd1));

    always_comb begin
        next_state = state;
        seq_clear  = 1'b0;
        case (state)
            READY: begin
                if (i_fm_flag) begin
                    next_state = RX_PAYLOAD;
                end
            end
            RX_PAYLOAD: begin
                if (bit_end) begin
                    seq_clear = 1'b1;
                    if (last_bit) begin
                        next_state = TURNAROUND;
                    end
                end
            end
            TURNAROUND: begin
                if (turn_end) begin
                    seq_clear  = 1'b1;
                    next_state = TX;
                end
            end
            TX: begin
                if (i_tx_done) begin
                    next_state = GUARD;
                end
            end
            GUARD: begin
                if (guard_end) begin
                    next_state = SEND_METADATA;
                end
            end
            SEND_METADATA: begin
                if (i_meta_done) begin
                    next_state = READY;
                end
            end
            default: next_state = READY;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= READY;
            payload_bit_ctr <= '0;
            guard_ctr       <= '0;
        end else begin
            state <= next_state;

            if (state != RX_PAYLOAD) begin
                payload_bit_ctr <= '0;
            end else if (bit_end) begin
                payload_bit_ctr <= payload_bit_ctr + 8'd1;
            end

            if (state != GUARD) begin
                guard_ctr <= '0;
            end else if (i_accept) begin
                guard_ctr <= guard_ctr + 16'd1;
            end
        end
    end

    // The keyer asks for its own wrap at the end of every transmit symbol
    assign o_cycle_clear = seq_clear || i_cycle_wrap;

    assign o_state              = state;
    assign o_timer_clear        = (state == READY);
    assign o_integrate          = (state == RX_PAYLOAD);
    assign o_bit_last           = bit_end;
    assign o_currently_decoding = (state != READY);
    assign o_detector_reset     = (state == TX) || (state == GUARD);
    assign o_tx_en              = (state == TX);

endmodule

// ==== logic/tx_pulse_keyer.sv ====
`timescale 1ns/1ps

module tx_pulse_keyer
    import mrr_loopback_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_tx_en,
    input  loopback_cfg_t              i_cfg,
    input  logic [CYCLE_IDX_WIDTH-1:0] i_cycle_idx,
    input  logic                       i_cycle_end,
    output logic                       o_tkeep,
    output logic                       o_tx_done,
    output logic                       o_cycle_wrap
);

    logic [TX_BIT_IDX_WIDTH-1:0] bit_idx;
    logic                        cur_bit;
    logic                        pulse_slot;

    // Bit 0 of the transmit word goes out first
    assign cur_bit    = i_cfg.tx_word[bit_idx];
    assign pulse_slot = cur_bit ? (i_cycle_idx == CYCLE_IDX_WIDTH'(TX_ONE_SLOT))
                                : (i_cycle_idx == CYCLE_IDX_WIDTH'(TX_ZERO_SLOT));

    assign o_tkeep      = i_tx_en && !i_cfg.tx_disable && pulse_slot;
    assign o_cycle_wrap = i_tx_en && i_cycle_end &&
                          (i_cycle_idx == CYCLE_IDX_WIDTH'(TX_SYMBOL_CYCLES - 1));
    assign o_tx_done    = o_cycle_wrap && (bit_idx == TX_BIT_IDX_WIDTH'(TX_BITS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_idx <= '0;
        end else if (!i_tx_en) begin
            bit_idx <= '0;
        end else if (o_cycle_wrap) begin
            bit_idx <= bit_idx + 1'b1;
        end
    end

endmodule

// ==== logic/report_formatter.sv ====
`timescale 1ns/1ps

module report_formatter
    import mrr_loopback_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  loop_state_t   i_state,
    input  energy_word_t  i_word,
    input  logic          i_word_valid,
    input  logic          i_bit_last,
    input  rx_metadata_t  i_meta,
    output decoded_beat_t o_decoded,
    output logic          o_meta_done
);

    logic [META_IDX_WIDTH-1:0] meta_idx;
    logic [31:0]               meta_word;
    logic                      meta_phase;
    logic                      bit_last_q;

    assign meta_phase  = (i_state == SEND_METADATA);
    assign o_meta_done = meta_phase && (meta_idx == META_IDX_WIDTH'(NUM_METADATA - 1));

    always_comb begin
        case (meta_idx)
            3'd0:    meta_word = i_meta.cfo;
            3'd1:    meta_word = i_meta.sfo;
            3'd2:    meta_word = i_meta.timestamp[63:32];
            3'd3:    meta_word = i_meta.timestamp[31:0];
            3'd4:    meta_word = i_meta.corr;
            3'd5:    meta_word = i_meta.extra[63:32];
            default: meta_word = i_meta.extra[31:0];
        endcase
    end

    // The energy word arrives a clock after its cycle end, so the bit-last flag is delayed to match
    always_ff @(posedge clk) begin
        if (rst) begin
            meta_idx   <= '0;
            bit_last_q <= 1'b0;
        end else begin
            bit_last_q <= i_bit_last;
            if (!meta_phase) begin
                meta_idx <= '0;
            end else begin
                meta_idx <= meta_idx + 1'b1;
            end
        end
    end

    always_comb begin
        if (meta_phase) begin
            o_decoded.data  = meta_word;
            o_decoded.valid = 1'b1;
            o_decoded.last  = o_meta_done;
        end else begin
            o_decoded.data  = {{(32 - $bits(energy_word_t)){1'b0}}, i_word};
            o_decoded.valid = i_word_valid;
            o_decoded.last  = i_word_valid && bit_last_q;
        end
    end

endmodule

// ==== logic/mrr_loopback.sv ====
`timescale 1ns/1ps

module mrr_loopback
    import mrr_loopback_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [ESAMP_WIDTH-1:0] i_tdata,
    input  logic                   i_tvalid,
    input  logic                   i_tlast,
    input  logic                   i_tkeep,
    input  logic                   i_replay_flag,
    output logic                   i_tready,
    output logic                   o_tvalid,
    output logic                   o_tlast,
    output logic                   o_tkeep,
    input  logic                   o_tready,
    input  loopback_cfg_t          i_cfg,
    input  logic                   i_fm_flag,
    input  rx_metadata_t           i_meta,
    output decoded_beat_t          o_decoded,
    output logic                   o_currently_decoding,
    output logic                   o_detector_reset,
    output logic                   o_tx_en
);

    logic                       accept;
    logic                       cycle_end;
    logic [CYCLE_IDX_WIDTH-1:0] cycle_idx;
    logic                       timer_clear;
    logic                       cycle_clear;
    logic                       cycle_wrap;
    logic                       integrate;
    logic                       bit_last;
    logic                       tx_done;
    logic                       meta_done;
    loop_state_t                state;
    energy_word_t               word;
    logic                       word_valid;

    // The outgoing stream mirrors the incoming strobes
    assign o_tvalid = i_tvalid;
    assign o_tlast  = i_tlast;
    assign i_tready = o_tready;

    mrr_cycle_timer u_timer (
        .clk(clk), .rst(rst),
        .i_tvalid(i_tvalid), .i_tkeep(i_tkeep), .i_replay_flag(i_replay_flag),
        .i_tready(o_tready), .i_timer_clear(timer_clear), .i_cycle_clear(cycle_clear),
        .o_accept(accept), .o_cycle_end(cycle_end), .o_cycle_idx(cycle_idx)
    );

    energy_integrator u_integrator (
        .clk(clk), .rst(rst), .i_sample(i_tdata), .i_accept(accept),
        .i_cycle_end(cycle_end), .i_integrate(integrate),
        .o_word(word), .o_word_valid(word_valid)
    );

    loopback_sequencer u_sequencer (
        .clk(clk), .rst(rst), .i_fm_flag(i_fm_flag), .i_cfg(i_cfg),
        .i_accept(accept), .i_cycle_end(cycle_end), .i_cycle_idx(cycle_idx),
        .i_cycle_wrap(cycle_wrap), .i_tx_done(tx_done), .i_meta_done(meta_done),
        .o_state(state), .o_timer_clear(timer_clear), .o_cycle_clear(cycle_clear),
        .o_integrate(integrate), .o_bit_last(bit_last),
        .o_currently_decoding(o_currently_decoding),
        .o_detector_reset(o_detector_reset), .o_tx_en(o_tx_en)
    );

    tx_pulse_keyer u_keyer (
        .clk(clk), .rst(rst), .i_tx_en(o_tx_en), .i_cfg(i_cfg),
        .i_cycle_idx(cycle_idx), .i_cycle_end(cycle_end),
        .o_tkeep(o_tkeep), .o_tx_done(tx_done), .o_cycle_wrap(cycle_wrap)
    );

    report_formatter u_formatter (
        .clk(clk), .rst(rst), .i_state(state), .i_word(word),
        .i_word_valid(word_valid), .i_bit_last(bit_last), .i_meta(i_meta),
        .o_decoded(o_decoded), .o_meta_done(meta_done)
    );

endmodule

// ==== verification/mrr_loopback_tb.sv ====
`timescale 1ns/1ps

module mrr_loopback_tb
    import mrr_loopback_pkg::*;
;

    logic                   clk;
    logic                   rst;
    logic [ESAMP_WIDTH-1:0] i_tdata;
    logic                   i_tvalid;
    logic                   i_tlast;
    logic                   i_tkeep;
    logic                   i_replay_flag;
    logic                   i_tready;
    logic                   o_tvalid;
    logic                   o_tlast;
    logic                   o_tkeep;
    logic                   o_tready;
    loopback_cfg_t          i_cfg;
    logic                   i_fm_flag;
    rx_metadata_t           i_meta;
    decoded_beat_t          o_decoded;
    logic                   o_currently_decoding;
    logic                   o_detector_reset;
    logic                   o_tx_en;

    logic [15:0] samples [0:255];
    logic [31:0] exp_word [0:63];
    logic [31:0] exp_meta [0:6];
    logic [31:0] tx_bits;
    int          n_beats;
    int          value_errs;
    int          other_errs;
    int          seed;
    bit          golden_ok;
    longint      limit_ns;

    // Per-run counters, cleared by the monitor when a run is triggered
    int          sidx;
    int          beat_cnt;
    int          tx_cnt;
    int          pre_tx_cnt;
    int          guard_cnt;

    mrr_loopback dut (.*);

    always #50 clk = ~clk;

    task automatic next_line(input int fd, output string s);
        int code;
        s = "";
        while (!$feof(fd)) begin
            code = $fgets(s, fd);
            if (code > 0 && s.len() > 1 && s[0] != "#") begin
                return;
            end
        end
        s = "";
    endtask

    task automatic read_golden();
        int          fd;
        int          i;
        string       s;
        logic [15:0] ws;
        logic [15:0] gl;
        logic [31:0] tw;
        logic [7:0]  nb;
        logic [7:0]  rl;
        logic [63:0] tm;
        logic [63:0] ex;
        fd = $fopen("verification/mrr_loopback_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file");
            other_errs++;
            return;
        end
        next_line(fd, s);
        void'($sscanf(s, "%h %h %h %h %h", ws, tw, nb, rl, gl));
        i_cfg = '{wait_step: ws, tx_word: tw, num_payload_bits: nb, recharge_len: rl,
                  guard_len: gl, tx_disable: 1'b0};
        next_line(fd, s);
        void'($sscanf(s, "%h %h %h %h %h", i_meta.cfo, i_meta.sfo, tm, i_meta.corr, ex));
        i_meta.timestamp = tm;
        i_meta.extra     = ex;
        exp_meta = '{i_meta.cfo, i_meta.sfo, tm[63:32], tm[31:0], i_meta.corr,
                     ex[63:32], ex[31:0]};
        next_line(fd, s);
        void'($sscanf(s, "%b", tx_bits));
        n_beats = int'(nb) * (int'(rl) + 3);
        for (i = 0; i < n_beats; i++) begin
            next_line(fd, s);
            void'($sscanf(s, "%h %h %h %h %h", samples[4*i], samples[4*i+1],
                          samples[4*i+2], samples[4*i+3], exp_word[i]));
        end
        $fclose(fd);
        golden_ok = 1'b1;
    endtask

    // Random valid gaps and back-pressure while the controller is busy
    always @(negedge clk) begin
        int r;
        if (o_currently_decoding) begin
            r        = $random(seed);
            i_tvalid = (r[1:0] != 2'b00);
            o_tready = (r[4:2] != 3'b000);
            i_tlast  = r[5];
            i_tdata  = (sidx < 4 * n_beats) ? samples[sidx] : 16'(sidx);
        end else begin
            i_tvalid = 1'b0;
            i_tlast  = 1'b0;
            o_tready = 1'b1;
        end
    end

    always @(posedge clk) begin
        bit accepted;
        bit exp_keep;
        bit exp_last;
        int pos;
        accepted = i_tvalid && o_tready && i_tkeep;
        // The outgoing strobes and the ready copy follow the inputs combinationally
        if (o_tvalid != i_tvalid || o_tlast != i_tlast || i_tready != o_tready) begin
            $display("[ERROR] o_tvalid o_tlast i_tready: got %h %h %h expected %h %h %h",
                     o_tvalid, o_tlast, i_tready, i_tvalid, i_tlast, o_tready);
            value_errs++;
        end
        if (rst) begin
            sidx = 0;
        end else if (i_fm_flag) begin
            sidx       = 0;
            beat_cnt   = 0;
            tx_cnt     = 0;
            pre_tx_cnt = 0;
            guard_cnt  = 0;
        end else begin
            if (!o_currently_decoding && (o_decoded.valid || o_tx_en || o_detector_reset
                                          || o_tkeep)) begin
                $display("Outputs active while the controller is idle");
                other_errs++;
            end
            if (o_decoded.valid) begin
                if (beat_cnt < n_beats) begin
                    exp_last = (beat_cnt % (int'(i_cfg.recharge_len) + 3))
                               == int'(i_cfg.recharge_len) + 2;
                    if (o_decoded.data != exp_word[beat_cnt] || o_decoded.last != exp_last) begin
                        $display("[ERROR] o_decoded beat %0d: data %h last %h, expected %h %h",
                                 beat_cnt, o_decoded.data, o_decoded.last,
                                 exp_word[beat_cnt], exp_last);
                        value_errs++;
                    end
                end else if (beat_cnt < n_beats + 7) begin
                    exp_last = (beat_cnt == n_beats + 6);
                    if (o_decoded.data != exp_meta[beat_cnt - n_beats]
                        || o_decoded.last != exp_last) begin
                        $display("[ERROR] o_decoded meta %0d: data %h last %h, expected %h %h",
                                 beat_cnt - n_beats, o_decoded.data, o_decoded.last,
                                 exp_meta[beat_cnt - n_beats], exp_last);
                        value_errs++;
                    end
                end
                beat_cnt++;
            end
            if (accepted && o_currently_decoding) begin
                sidx++;
                if (o_tx_en) begin
                    // Bit 0 of the word is the leftmost golden digit and goes out first
                    pos      = tx_cnt % 20;
                    exp_keep = tx_bits[31 - (tx_cnt / 20) % 32] ? (pos < 4)
                                                               : (pos >= 8 && pos < 12);
                    if (i_cfg.tx_disable) begin
                        exp_keep = 1'b0;
                    end
                    if (o_tkeep != exp_keep) begin
                        $display("[ERROR] o_tkeep at TX sample %0d: got %h expected %h",
                                 tx_cnt, o_tkeep, exp_keep);
                        value_errs++;
                    end
                    if (!o_detector_reset) begin
                        $display("[ERROR] o_detector_reset at TX sample %0d: got %h expected 1",
                                 tx_cnt, o_detector_reset);
                        value_errs++;
                    end
                    tx_cnt++;
                end else if (o_detector_reset) begin
                    guard_cnt++;
                end else if (tx_cnt == 0) begin
                    pre_tx_cnt++;
                end
            end
        end
    end

    task automatic check_count(input string name, input int got, input int expected);
        if (got != expected) begin
            $display("[ERROR] %s: got %h expected %h", name, got, expected);
            value_errs++;
        end
    endtask

    task automatic run_loopback(input bit tx_off);
        i_cfg.tx_disable = tx_off;
        @(negedge clk);
        i_fm_flag = 1'b1;
        @(negedge clk);
        i_fm_flag = 1'b0;
        if (!o_currently_decoding) begin
            $display("Controller did not start after the trigger");
            other_errs++;
        end
        while (o_currently_decoding) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        check_count("decoded beat count", beat_cnt, n_beats + 7);
        check_count("samples before o_tx_en", pre_tx_cnt,
                    4 * n_beats + 4 * int'(i_cfg.wait_step));
        check_count("o_tx_en samples", tx_cnt, TX_BITS * TX_SYMBOL_CYCLES * 4);
        check_count("guard samples", guard_cnt, int'(i_cfg.guard_len));
    endtask

    // The watchdog allows four clocks for every sample of both runs
    initial begin
        wait (golden_ok);
        limit_ns = 4 * 100 * 2 * (4 * n_beats + 4 * longint'(i_cfg.wait_step)
                   + TX_BITS * TX_SYMBOL_CYCLES * 4 + longint'(i_cfg.guard_len) + 64);
        #(limit_ns);
        $display("Timeout: the run did not finish in %0d ns", limit_ns);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        seed          = 32'h9f10;
        clk           = 1'b0;
        rst           = 1'b1;
        i_tdata       = '0;
        i_tvalid      = 1'b0;
        i_tlast       = 1'b0;
        i_tkeep       = 1'b1;
        i_replay_flag = 1'b0;
        o_tready      = 1'b1;
        i_fm_flag     = 1'b0;
        i_cfg         = '0;
        i_meta        = '0;
        value_errs    = 0;
        other_errs    = 0;
        golden_ok     = 1'b0;
        n_beats       = 0;
        read_golden();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (8) @(negedge clk);
        if (o_currently_decoding) begin
            $display("[ERROR] o_currently_decoding after reset: got %h expected 0",
                     o_currently_decoding);
            value_errs++;
        end
        if (golden_ok) begin
            run_loopback(1'b0);
            run_loopback(1'b1);
        end
        $display("Errors: %0d value, %0d other", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== verification/mrr_loopback_golden.txt ====
# Config, hex: wait_step tx_word num_payload_bits recharge_len guard_len
# Then metadata (cfo sfo time corr extra), transmit bits and one line per payload cycle
0003 a5c30f96 02 01 000a
# Metadata, hex: cfo sfo time corr extra
11223344 55667788 0123456789abcdef 99aabbcc fedcba9876543210
# Transmit bits in binary, first transmitted bit on the left
01101001111100001100001110100101
# Payload cycles, hex: four samples and the expected decoded word
0010 0020 0030 0040 001000a0
1000 2000 3000 4000 0010a000
ffff ffff ffff ffff 0013fffc
0001 0002 0003 0004 0010000a
8000 8000 0000 0001 00110001
1234 4321 0abc 0def 00106e00
00ff 0f00 f000 0001 00110000
7fff 7fff 7fff 7fff 0011fffc

// ==== mrr_loopback.f ====
logic/mrr_loopback_pkg.sv
logic/mrr_cycle_timer.sv
logic/energy_integrator.sv
logic/loopback_sequencer.sv
logic/tx_pulse_keyer.sv
logic/report_formatter.sv
logic/mrr_loopback.sv
verification/mrr_loopback_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= mrr_loopback_tb
FILELIST  ?= mrr_loopback.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
